//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_debug_unit
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard rtl/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- project.f
+incdir+sim
rtl/du_pkg.sv
rtl/program_loader.sv
rtl/word_dumper.sv
rtl/debug_controller.sv
rtl/debug_unit.sv
sim/tb_debug_unit.sv

//--- rtl/debug_controller.sv
`timescale 1ns/1ps

module debug_controller (
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_rx_done,
    input  du_pkg::byte_t     i_rx_data,
    input  logic              i_hlt,
    input  logic              i_load_done,
    input  logic              i_dump_done,
    output logic              o_load_start,
    output logic              o_dump_start,
    output du_pkg::dump_src_e o_dump_src,
    output logic              o_run_enable,
    output logic              o_step_mode,
    output logic              o_step
);
    import du_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOADING,
        ST_READY,
        ST_RUNNING,
        ST_STEPPING,
        ST_DUMPING,
        ST_STEP_DUMPING
    } state_e;

    state_e    state;
    state_e    next_state;
    cmd_e      cmd;
    dump_src_e chain_src;       // Dump in flight during a step
    dump_src_e next_chain_src;
    logic      step_req;        // One cycle ahead of o_step
    logic      next_step_req;

    assign cmd = cmd_e'(i_rx_data);

    always_comb begin
        next_state     = state;
        next_chain_src = chain_src;
        next_step_req  = 1'b0;
        o_load_start   = 1'b0;
        o_dump_start   = 1'b0;
        o_dump_src     = DUMP_PC;

        case (state)
            ST_IDLE: begin
                if (i_rx_done) begin
                    case (cmd)
                        CMD_WRITE_PROG: begin
                            o_load_start = 1'b1;
                            next_state   = ST_LOADING;
                        end
                        CMD_SEND_RB: begin
                            o_dump_start = 1'b1;
                            o_dump_src   = DUMP_RB;
                            next_state   = ST_DUMPING;
                        end
                        CMD_SEND_DM: begin
                            o_dump_start = 1'b1;
                            o_dump_src   = DUMP_DM;
                            next_state   = ST_DUMPING;
                        end
                        CMD_SEND_PC: begin
                            o_dump_start = 1'b1;
                            o_dump_src   = DUMP_PC;
                            next_state   = ST_DUMPING;
                        end
                        default: ;  // Anything else is dropped
                    endcase
                end
            end
            ST_LOADING: begin
                if (i_load_done) begin
                    next_state = ST_READY;
                end
            end
            ST_READY: begin
                if (i_rx_done && cmd == CMD_START) begin
                    next_state = ST_RUNNING;
                end else if (i_rx_done && cmd == CMD_STEP_MODE) begin
                    next_state = ST_STEPPING;
                end
            end
            ST_RUNNING: begin
                if (i_hlt) begin
                    next_state = ST_IDLE;
                end
            end
            ST_STEPPING: begin
                if (i_hlt) begin
                    next_state = ST_IDLE;
                end else if (i_rx_done && cmd == CMD_STEP) begin
                    next_step_req  = 1'b1;
                    next_chain_src = DUMP_PC;
                    next_state     = ST_STEP_DUMPING;
                end else if (i_rx_done && cmd == CMD_CONTINUE) begin
                    next_state = ST_RUNNING;
                end
            end
            ST_DUMPING: begin
                if (i_dump_done) begin
                    next_state = ST_IDLE;
                end
            end
            ST_STEP_DUMPING: begin
                // PC dump starts with the step pulse, then DM and RB follow
                if (o_step) begin
                    o_dump_start = 1'b1;
                    o_dump_src   = DUMP_PC;
                end else if (i_dump_done) begin
                    case (chain_src)
                        DUMP_PC: begin
                            o_dump_start   = 1'b1;
                            o_dump_src     = DUMP_DM;
                            next_chain_src = DUMP_DM;
                        end
                        DUMP_DM: begin
                            o_dump_start   = 1'b1;
                            o_dump_src     = DUMP_RB;
                            next_chain_src = DUMP_RB;
                        end
                        default: next_state = ST_STEPPING;
                    endcase
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state        <= ST_IDLE;
            chain_src    <= DUMP_PC;
            step_req     <= 1'b0;
            o_step       <= 1'b0;
            o_run_enable <= 1'b0;
            o_step_mode  <= 1'b0;
        end else begin
            state        <= next_state;
            chain_src    <= next_chain_src;
            step_req     <= next_step_req;
            o_step       <= step_req;
            o_run_enable <= (next_state == ST_RUNNING);
            o_step_mode  <= (next_state == ST_STEPPING) ||
                            (next_state == ST_STEP_DUMPING);
        end
    end

    a_single_start: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(o_load_start && o_dump_start)
    );

endmodule

//--- rtl/debug_unit.sv
`timescale 1ns/1ps

module debug_unit #(
    parameter int PROG_BYTES = 40,
    parameter int DM_DEPTH   = 32,   // At most 32 words
    parameter int RB_DEPTH   = 32    // At most 32 registers
) (
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             i_rx_done,
    input  du_pkg::byte_t    i_rx_data,
    input  logic             i_tx_done,
    input  logic             i_hlt,
    input  du_pkg::word_t    i_pc_value,
    input  du_pkg::word_t    i_dm_data,
    input  du_pkg::word_t    i_br_data,
    output du_pkg::byte_t    o_tx_data,
    output logic             o_tx_start,
    output logic             o_im_write_enable,
    output du_pkg::im_addr_t o_im_addr,
    output du_pkg::byte_t    o_im_data,
    output du_pkg::dm_addr_t o_dm_addr,
    output logic             o_dm_select,
    output du_pkg::rb_addr_t o_rb_addr,
    output logic             o_rb_read_enable,
    output logic             o_run_enable,
    output logic             o_step_mode,
    output logic             o_step
);
    import du_pkg::*;

    logic      load_start;
    logic      load_done;
    logic      dump_start;
    logic      dump_done;
    dump_src_e dump_src;

    debug_controller ctrl_i (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_rx_done    (i_rx_done),
        .i_rx_data    (i_rx_data),
        .i_hlt        (i_hlt),
        .i_load_done  (load_done),
        .i_dump_done  (dump_done),
        .o_load_start (load_start),
        .o_dump_start (dump_start),
        .o_dump_src   (dump_src),
        .o_run_enable (o_run_enable),
        .o_step_mode  (o_step_mode),
        .o_step       (o_step)
    );

    // Shares the RX byte stream with the controller
    program_loader #(
        .PROG_BYTES (PROG_BYTES)
    ) loader_i (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_load_start      (load_start),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .o_im_write_enable (o_im_write_enable),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data),
        .o_done            (load_done)
    );

    word_dumper #(
        .DM_DEPTH (DM_DEPTH),
        .RB_DEPTH (RB_DEPTH)
    ) dumper_i (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_dump_start     (dump_start),
        .i_dump_src       (dump_src),
        .i_tx_done        (i_tx_done),
        .i_pc_value       (i_pc_value),
        .i_dm_data        (i_dm_data),
        .i_br_data        (i_br_data),
        .o_tx_data        (o_tx_data),
        .o_tx_start       (o_tx_start),
        .o_dm_addr        (o_dm_addr),
        .o_dm_select      (o_dm_select),
        .o_rb_addr        (o_rb_addr),
        .o_rb_read_enable (o_rb_read_enable),
        .o_done           (dump_done)
    );

endmodule

//--- rtl/du_pkg.sv
package du_pkg;

    // Link and processor widths
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    typedef logic [7:0]  im_addr_t;   // Instruction memory byte address
    typedef logic [4:0]  rb_addr_t;   // Register bank index
    typedef logic [4:0]  dm_addr_t;   // Data memory word address

    // Words go out MSB first, one byte per transfer
    localparam int BYTES_PER_WORD = 4;

    // Command bytes received over the UART
    typedef enum logic [7:0] {
        CMD_WRITE_PROG = 8'd1,
        CMD_START      = 8'd2,
        CMD_STEP_MODE  = 8'd3,
        CMD_SEND_RB    = 8'd4,
        CMD_SEND_DM    = 8'd5,
        CMD_SEND_PC    = 8'd6,
        CMD_STEP       = 8'd7,
        CMD_CONTINUE   = 8'd8
    } cmd_e;

    // Source walked by the word dumper
    typedef enum logic [1:0] {
        DUMP_PC = 2'd0,
        DUMP_DM = 2'd1,
        DUMP_RB = 2'd2
    } dump_src_e;

endpackage

//--- rtl/program_loader.sv
`timescale 1ns/1ps

module program_loader #(
    parameter int PROG_BYTES = 40
) (
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             i_load_start,
    input  logic             i_rx_done,
    input  du_pkg::byte_t    i_rx_data,
    output logic             o_im_write_enable,
    output du_pkg::im_addr_t o_im_addr,
    output du_pkg::byte_t    o_im_data,
    output logic             o_done
);
    import du_pkg::*;

    localparam im_addr_t LAST_ADDR = im_addr_t'(PROG_BYTES - 1);

    logic     armed;     // Counting program bytes
    im_addr_t wr_addr;   // Address for the next received byte

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            armed             <= 1'b0;
            wr_addr           <= '0;
            o_im_write_enable <= 1'b0;
            o_im_addr         <= '0;
            o_done            <= 1'b0;
        end else begin
            o_im_write_enable <= 1'b0;
            o_done            <= 1'b0;
            if (i_load_start) begin
                armed   <= 1'b1;
                wr_addr <= '0;
            end else if (armed && i_rx_done) begin
                o_im_write_enable <= 1'b1;
                o_im_addr         <= wr_addr;
                wr_addr           <= wr_addr + 1'b1;
                // Last byte closes the load
                if (wr_addr == LAST_ADDR) begin
                    armed  <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // Byte travels with its write strobe
    always_ff @(posedge i_clock) begin
        if (armed && i_rx_done) begin
            o_im_data <= i_rx_data;
        end
    end

    a_write_in_range: assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_im_write_enable |-> (int'(o_im_addr) < PROG_BYTES)
    );

endmodule

//--- rtl/word_dumper.sv
`timescale 1ns/1ps

module word_dumper #(
    parameter int DM_DEPTH = 32,
    parameter int RB_DEPTH = 32
) (
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_dump_start,
    input  du_pkg::dump_src_e i_dump_src,
    input  logic              i_tx_done,
    input  du_pkg::word_t     i_pc_value,
    input  du_pkg::word_t     i_dm_data,
    input  du_pkg::word_t     i_br_data,
    output du_pkg::byte_t     o_tx_data,
    output logic              o_tx_start,
    output du_pkg::dm_addr_t  o_dm_addr,
    output logic              o_dm_select,
    output du_pkg::rb_addr_t  o_rb_addr,
    output logic              o_rb_read_enable,
    output logic              o_done
);
    import du_pkg::*;

    localparam int BYTE_CNT_W = $clog2(BYTES_PER_WORD);
    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE = BYTE_CNT_W'(BYTES_PER_WORD - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,    // Address settles, read data follows next cycle
        ST_SEND,    // Byte offered until the transmitter acknowledges
        ST_GAP      // Start drops between bytes of one word
    } state_e;

    state_e                state;
    dump_src_e             src_q;
    dm_addr_t              word_cnt;
    dm_addr_t              last_word;
    logic [BYTE_CNT_W-1:0] byte_cnt;
    word_t                 cur_word;
    word_t                 shifted;

    // Word source and its length
    always_comb begin
        case (src_q)
            DUMP_DM: begin
                cur_word  = i_dm_data;
                last_word = dm_addr_t'(DM_DEPTH - 1);
            end
            DUMP_RB: begin
                cur_word  = i_br_data;
                last_word = dm_addr_t'(RB_DEPTH - 1);
            end
            default: begin
                cur_word  = i_pc_value;  // PC is a single word
                last_word = '0;
            end
        endcase
    end

    // MSB first, so byte 0 is the top of the word
    assign shifted    = cur_word << {byte_cnt, 3'b000};
    assign o_tx_data  = shifted[$bits(word_t)-1 -: $bits(byte_t)];
    assign o_tx_start = (state == ST_SEND);

    assign o_dm_addr = word_cnt;
    assign o_rb_addr = rb_addr_t'(word_cnt);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state            <= ST_IDLE;
            src_q            <= DUMP_PC;
            word_cnt         <= '0;
            byte_cnt         <= '0;
            o_dm_select      <= 1'b0;
            o_rb_read_enable <= 1'b0;
            o_done           <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_dump_start) begin
                        src_q            <= i_dump_src;
                        word_cnt         <= '0;
                        byte_cnt         <= '0;
                        o_dm_select      <= (i_dump_src == DUMP_DM);
                        o_rb_read_enable <= (i_dump_src == DUMP_RB);
                        state            <= ST_ADDR;
                    end
                end
                ST_ADDR: state <= ST_SEND;
                ST_SEND: begin
                    if (i_tx_done) begin
                        if (byte_cnt == LAST_BYTE) begin
                            byte_cnt <= '0;
                            if (word_cnt == last_word) begin
                                word_cnt         <= '0;
                                o_dm_select      <= 1'b0;
                                o_rb_read_enable <= 1'b0;
                                o_done           <= 1'b1;
                                state            <= ST_IDLE;
                            end else begin
                                word_cnt <= word_cnt + 1'b1;  // Next address
                                state    <= ST_ADDR;
                            end
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= ST_GAP;
                        end
                    end
                end
                ST_GAP:  state <= ST_SEND;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Source data must hold while a byte is on offer
    a_tx_data_stable: assert property (
        @(posedge i_clock) disable iff (i_reset)
        (o_tx_start && $past(o_tx_start)) |-> $stable(o_tx_data)
    );

endmodule

//--- sim/du_tests.svh
// One received byte with its strobe held for a single cycle
task automatic send_rx(byte_t value);
    @(negedge i_clock);
    i_rx_data = value;
    i_rx_done = 1'b1;
    @(negedge i_clock);
    i_rx_done = 1'b0;
endtask

task automatic wait_tx_count(int target, logic hold_step_mode);
    int cycles = 0;
    while (tx_log.size() < target) begin
        if (cycles == TIMEOUT) fail_now("timeout while waiting for transmitted bytes");
        if (hold_step_mode) check_level(o_step_mode, 1'b1, "o_step_mode during the dump");
        cycles++;
        @(negedge i_clock);
    end
endtask

task automatic wait_run_enable(logic level);
    int cycles = 0;
    while (o_run_enable !== level) begin
        if (cycles == TIMEOUT) fail_now("timeout while waiting for the run enable to change");
        cycles++;
        @(negedge i_clock);
    end
endtask

// No further bytes may follow a finished dump
task automatic expect_quiet(int count);
    repeat (12) @(negedge i_clock);
    if (tx_log.size() != count) begin
        fail_now($sformatf("error at %0d ns: %0d bytes sent, expected %0d",
                           $time, tx_log.size(), count));
    end
    check_level(o_dm_select, 1'b0, "o_dm_select after the dump");
    check_level(o_rb_read_enable, 1'b0, "o_rb_read_enable after the dump");
endtask

task automatic check_dump_word(int index, word_t exp, string what);
    word_t got;
    got = {tx_log[index], tx_log[index + 1], tx_log[index + 2], tx_log[index + 3]};
    check_word(got, exp, what);   // MSB arrives first
endtask

task automatic halt_processor();
    @(negedge i_clock);
    check_level(o_run_enable, 1'b1, "o_run_enable before the halt");
    i_hlt = 1'b1;
    wait_run_enable(1'b0);
    i_hlt = 1'b0;
endtask

task automatic load_program();
    byte_t prog[PROG_BYTES];
    int    first;
    int    cycles;
    first  = im_addr_log.size();
    cycles = 0;
    send_rx(byte_t'(CMD_WRITE_PROG));
    for (int i = 0; i < PROG_BYTES; i++) begin
        prog[i] = byte_t'(next_random() >> 24);
        send_rx(prog[i]);
    end
    while (im_addr_log.size() < first + PROG_BYTES) begin
        if (cycles == TIMEOUT) fail_now("timeout while waiting for instruction writes");
        cycles++;
        @(negedge i_clock);
    end
    for (int i = 0; i < PROG_BYTES; i++) begin
        check_byte(im_addr_log[first + i], byte_t'(i), "o_im_addr");
        check_byte(im_data_log[first + i], prog[i], "o_im_data");
    end
endtask

task automatic test_reset_state();
    check_level(o_tx_start, 1'b0, "o_tx_start");
    check_level(o_im_write_enable, 1'b0, "o_im_write_enable");
    check_level(o_dm_select, 1'b0, "o_dm_select");
    check_level(o_rb_read_enable, 1'b0, "o_rb_read_enable");
    check_level(o_run_enable, 1'b0, "o_run_enable");
    check_level(o_step_mode, 1'b0, "o_step_mode");
    check_level(o_step, 1'b0, "o_step");
    check_byte(o_im_addr, 8'h00, "o_im_addr");
    check_byte(byte_t'(o_dm_addr), 8'h00, "o_dm_addr");
    check_byte(byte_t'(o_rb_addr), 8'h00, "o_rb_addr");
endtask

task automatic test_load_and_run();
    load_program();
    send_rx(byte_t'(CMD_START));
    wait_run_enable(1'b1);
    halt_processor();
endtask

task automatic test_pc_dump();
    int first;
    first = tx_log.size();
    send_rx(byte_t'(CMD_SEND_PC));
    check_level(o_tx_start, 1'b0, "o_tx_start one cycle after the command");
    @(negedge i_clock);
    check_level(o_tx_start, 1'b1, "o_tx_start two cycles after the command");
    wait_tx_count(first + BYTES_PER_WORD, 1'b0);
    expect_quiet(first + BYTES_PER_WORD);
    check_dump_word(first, i_pc_value, "program counter");
endtask

task automatic test_mem_dumps();
    int first;
    first = tx_log.size();
    send_rx(byte_t'(CMD_SEND_DM));
    wait_tx_count(first + BYTES_PER_WORD * DM_DEPTH, 1'b0);
    expect_quiet(first + BYTES_PER_WORD * DM_DEPTH);
    for (int a = 0; a < DM_DEPTH; a++) begin
        check_dump_word(first + BYTES_PER_WORD * a, dm_word(a), "data memory word");
    end
    first = tx_log.size();
    send_rx(byte_t'(CMD_SEND_RB));
    wait_tx_count(first + BYTES_PER_WORD * RB_DEPTH, 1'b0);
    expect_quiet(first + BYTES_PER_WORD * RB_DEPTH);
    for (int a = 0; a < RB_DEPTH; a++) begin
        check_dump_word(first + BYTES_PER_WORD * a, rb_word(a), "register");
    end
endtask

task automatic test_step_mode();
    int first;
    int pulses;
    int total;
    total = BYTES_PER_WORD * (1 + DM_DEPTH + RB_DEPTH);
    load_program();
    send_rx(byte_t'(CMD_STEP_MODE));
    check_level(o_step_mode, 1'b1, "o_step_mode after the step mode command");
    first  = tx_log.size();
    pulses = step_pulses;
    send_rx(byte_t'(CMD_STEP));
    check_level(o_step, 1'b0, "o_step one cycle after the command");
    @(negedge i_clock);
    check_level(o_step, 1'b1, "o_step two cycles after the command");
    wait_tx_count(first + total, 1'b1);
    expect_quiet(first + total);
    if (step_pulses - pulses != 1) fail_now("the step command gave other than one step pulse");
    check_level(o_step_mode, 1'b1, "o_step_mode after the dump");
    check_dump_word(first, i_pc_value, "program counter");
    for (int a = 0; a < DM_DEPTH; a++) begin
        check_dump_word(first + BYTES_PER_WORD * (1 + a), dm_word(a), "data memory word");
    end
    for (int a = 0; a < RB_DEPTH; a++) begin
        check_dump_word(first + BYTES_PER_WORD * (1 + DM_DEPTH + a), rb_word(a), "register");
    end
    send_rx(byte_t'(CMD_CONTINUE));
    wait_run_enable(1'b1);
    halt_processor();
endtask

task automatic run_tests();
    test_reset_state();
    test_load_and_run();
    test_pc_dump();
    test_mem_dumps();
    test_step_mode();
endtask

//--- sim/tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit;
    import du_pkg::*;

    localparam int PROG_BYTES = 8;
    localparam int DM_DEPTH   = 4;
    localparam int RB_DEPTH   = 4;
    localparam int TIMEOUT    = 2000;   // Cycles allowed for any single wait

    logic     i_clock   = 1'b0;
    logic     i_reset;
    logic     i_rx_done;
    byte_t    i_rx_data;
    logic     i_tx_done = 1'b0;
    logic     i_hlt;
    word_t    i_pc_value;
    word_t    i_dm_data = '0;
    word_t    i_br_data = '0;
    byte_t    o_tx_data;
    logic     o_tx_start;
    logic     o_im_write_enable;
    im_addr_t o_im_addr;
    byte_t    o_im_data;
    dm_addr_t o_dm_addr;
    logic     o_dm_select;
    rb_addr_t o_rb_addr;
    logic     o_rb_read_enable;
    logic     o_run_enable;
    logic     o_step_mode;
    logic     o_step;

    word_t    lcg_state = 32'h2f72644a;
    byte_t    tx_log[$];        // Bytes acknowledged by the transmit responder
    im_addr_t im_addr_log[$];
    byte_t    im_data_log[$];
    int       step_pulses = 0;
    logic     tx_armed    = 1'b0;
    int       tx_delay    = 0;

    always #20 i_clock = ~i_clock;

    debug_unit #(
        .PROG_BYTES (PROG_BYTES),
        .DM_DEPTH   (DM_DEPTH),
        .RB_DEPTH   (RB_DEPTH)
    ) dut_i (.*);

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t dm_word(int addr);
        return 32'hD000_0000 + word_t'(addr) * 32'h0101_0101;
    endfunction

    function automatic word_t rb_word(int addr);
        return 32'hB000_0000 + word_t'(addr);
    endfunction

    // Processor model with read data that follows the address
    always @(negedge i_clock) begin
        i_dm_data = o_dm_select ? dm_word(int'(o_dm_addr)) : '0;   // Only while selected
        i_br_data = o_rb_read_enable ? rb_word(int'(o_rb_addr)) : '0;
    end

    // Transmit responder with a random 1 to 6 cycle acknowledge
    always @(negedge i_clock) begin
        if (i_reset) begin
            i_tx_done = 1'b0;
            tx_armed  = 1'b0;
        end else if (i_tx_done) begin
            i_tx_done = 1'b0;   // Done is a one cycle strobe
        end else if (o_tx_start) begin
            if (!tx_armed) begin
                tx_armed = 1'b1;
                tx_delay = 1 + int'(next_random() % 32'd6);
            end
            tx_delay = tx_delay - 1;
            if (tx_delay == 0) begin
                i_tx_done = 1'b1;
                tx_armed  = 1'b0;
                tx_log.push_back(o_tx_data);
            end
        end
    end

    always @(negedge i_clock) begin
        if (o_im_write_enable) begin
            im_addr_log.push_back(o_im_addr);
            im_data_log.push_back(o_im_data);
        end
        if (o_step) step_pulses++;
    end

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_level(logic got, logic exp, string what);
        if (got !== exp) begin
            fail_now($sformatf("error at %0d ns: %s is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_byte(byte_t got, byte_t exp, string what);
        if (got !== exp) begin
            fail_now($sformatf("error at %0d ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            fail_now($sformatf("error at %0d ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    `include "du_tests.svh"

    initial begin
        i_reset    = 1'b1;
        i_rx_done  = 1'b0;
        i_rx_data  = '0;
        i_hlt      = 1'b0;
        i_pc_value = next_random();
        repeat (4) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        run_tests();
        $display("TESTS PASSED");
        $finish;
    end

endmodule
